// ==== filelist.f ====
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/core_pipe_pkg.sv
hdl/int_decode.sv
hdl/int_execute.sv
hdl/int_result.sv
hdl/int_core.sv
testbench/int_core_checker.sv
testbench/tb_int_core.sv

// ==== Bender.yml ====
package:
  name: int_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_isa_pkg.sv
      - hdl/core_pipe_pkg.sv
      - hdl/int_decode.sv
      - hdl/int_execute.sv
      - hdl/int_result.sv
      - hdl/int_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/int_core_checker.sv
      - testbench/tb_int_core.sv

// ==== testbench/tb_int_core.sv ====
// integer core testbench
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module tb_int_core
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;
();

    localparam logic [6:0] op_r     = 7'h33;
    localparam logic [6:0] op_i     = 7'h13;
    localparam logic [6:0] op_rw    = 7'h3b;
    localparam logic [6:0] op_iw    = 7'h1b;
    localparam logic [6:0] op_lui   = 7'h37;
    localparam logic [6:0] op_auipc = 7'h17;

    typedef struct packed {
        logic [31:0]           inst;
        logic [`XLEN-1:0]      pc;
        logic [`REG_IDX_W-1:0] rd;  // 0 marks an instruction with no writeback.
        logic [`XLEN-1:0]      data;
        logic [1:0]            gap;  // idle cycles after the strobe.
    } entry_t;

    logic                  clk;
    logic                  rst_n;
    logic                  inst_valid;
    inst_u                 inst;
    logic [`XLEN-1:0]      pc;
    logic                  wb_valid;
    logic [`REG_IDX_W-1:0] wb_rd;
    logic [`XLEN-1:0]      wb_data;
    wb_t                   expect_wb;
    logic                  final_check;
    int                    errors;
    int                    seen;
    int                    cycles = 0;
    entry_t                table_q[$];
    logic [`XLEN-1:0]      pc_next = 64'h1000;
    logic [1:0]            gap_next = 2'd3;

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    task automatic add_entry(input logic [31:0] word, input logic [4:0] rd,
                             input logic [`XLEN-1:0] data);
        entry_t e;
        e.inst = word;
        e.pc   = pc_next;
        e.rd   = rd;
        e.data = data;
        e.gap  = gap_next;
        table_q.push_back(e);
        pc_next = pc_next + 4;
    endtask

    task automatic fill_table();
        // every register reads 0 after reset.
        for (int r = 1; r < `NUM_REGS; r++) begin
            add_entry(r_type(7'h00, 3'd0, 5'(r), 5'd0, 5'(r), op_r), 5'(r), 64'h0);
        end
        add_entry(u_type(20'h12345, 5'd1, op_lui), 5'd1, 64'h0000_0000_1234_5000);
        add_entry(u_type(20'h80000, 5'd2, op_lui), 5'd2, 64'hffff_ffff_8000_0000);
        pc_next = 64'h2000;
        add_entry(u_type(20'h00010, 5'd4, op_auipc), 5'd4, 64'h0000_0000_0001_2000);
        pc_next = 64'h3000;
        add_entry(u_type(20'hfffff, 5'd5, op_auipc), 5'd5, 64'h0000_0000_0000_2000);
        add_entry(i_type(12'hffb, 3'd0, 5'd6, 5'd0, op_i), 5'd6, 64'hffff_ffff_ffff_fffb);
        add_entry(i_type(12'h003, 3'd0, 5'd7, 5'd0, op_i), 5'd7, 64'h3);
        add_entry(i_type(12'h7ff, 3'd0, 5'd8, 5'd0, op_i), 5'd8, 64'h7ff);
        add_entry(r_type(7'h00, 3'd0, 5'd10, 5'd6, 5'd7, op_r), 5'd10, 64'hffff_ffff_ffff_fffe);
        add_entry(r_type(7'h20, 3'd0, 5'd12, 5'd6, 5'd7, op_r), 5'd12, 64'hffff_ffff_ffff_fff8);
        add_entry(r_type(7'h00, 3'd2, 5'd13, 5'd6, 5'd7, op_r), 5'd13, 64'h1);
        add_entry(r_type(7'h00, 3'd3, 5'd14, 5'd6, 5'd7, op_r), 5'd14, 64'h0);
        add_entry(r_type(7'h00, 3'd3, 5'd15, 5'd7, 5'd6, op_r), 5'd15, 64'h1);
        add_entry(r_type(7'h00, 3'd4, 5'd17, 5'd6, 5'd7, op_r), 5'd17, 64'hffff_ffff_ffff_fff8);
        add_entry(r_type(7'h00, 3'd7, 5'd19, 5'd6, 5'd8, op_r), 5'd19, 64'h7fb);
        add_entry(r_type(7'h00, 3'd6, 5'd3, 5'd6, 5'd8, op_r), 5'd3, 64'hffff_ffff_ffff_ffff);
        add_entry(i_type(12'hf0e, 3'd6, 5'd3, 5'd7, op_i), 5'd3, 64'hffff_ffff_ffff_ff0f);
        add_entry(i_type(12'h8f0, 3'd7, 5'd3, 5'd6, op_i), 5'd3, 64'hffff_ffff_ffff_f8f0);
        add_entry(r_type(7'h00, 3'd1, 5'd20, 5'd7, 5'd7, op_r), 5'd20, 64'h18);
        add_entry(r_type(7'h00, 3'd5, 5'd21, 5'd2, 5'd7, op_r), 5'd21, 64'h1fff_ffff_f000_0000);
        add_entry(r_type(7'h20, 3'd5, 5'd22, 5'd2, 5'd7, op_r), 5'd22, 64'hffff_ffff_f000_0000);
        add_entry(i_type(12'h028, 3'd1, 5'd23, 5'd7, op_i), 5'd23, 64'h0000_0300_0000_0000);
        add_entry(i_type(12'h020, 3'd5, 5'd24, 5'd2, op_i), 5'd24, 64'h0000_0000_ffff_ffff);
        add_entry(i_type(12'h43f, 3'd5, 5'd25, 5'd2, op_i), 5'd25, 64'hffff_ffff_ffff_ffff);
        add_entry(i_type(12'h028, 3'd1, 5'd26, 5'd6, op_i), 5'd26, 64'hffff_fb00_0000_0000);
        add_entry(i_type(12'h424, 3'd5, 5'd27, 5'd26, op_i), 5'd27, 64'hffff_ffff_ffff_ffb0);
        add_entry(i_type(12'h024, 3'd5, 5'd28, 5'd26, op_i), 5'd28, 64'h0000_0000_0fff_ffb0);
        add_entry(i_type(12'hffc, 3'd2, 5'd9, 5'd6, op_i), 5'd9, 64'h1);
        add_entry(i_type(12'hfff, 3'd3, 5'd11, 5'd7, op_i), 5'd11, 64'h1);
        add_entry(u_type(20'h7ffff, 5'd9, op_lui), 5'd9, 64'h0000_0000_7fff_f000);
        add_entry(r_type(7'h00, 3'd0, 5'd10, 5'd9, 5'd9, op_rw), 5'd10, 64'hffff_ffff_ffff_e000);
        add_entry(r_type(7'h00, 3'd0, 5'd11, 5'd9, 5'd9, op_r), 5'd11, 64'h0000_0000_ffff_e000);
        add_entry(r_type(7'h20, 3'd0, 5'd12, 5'd2, 5'd7, op_rw), 5'd12, 64'h0000_0000_7fff_fffd);
        add_entry(r_type(7'h00, 3'd1, 5'd13, 5'd9, 5'd7, op_rw), 5'd13, 64'hffff_ffff_ffff_8000);
        add_entry(r_type(7'h00, 3'd5, 5'd14, 5'd2, 5'd7, op_rw), 5'd14, 64'h0000_0000_1000_0000);
        add_entry(r_type(7'h20, 3'd5, 5'd15, 5'd2, 5'd7, op_rw), 5'd15, 64'hffff_ffff_f000_0000);
        add_entry(i_type(12'h01f, 3'd1, 5'd16, 5'd7, op_iw), 5'd16, 64'hffff_ffff_8000_0000);
        add_entry(i_type(12'h401, 3'd5, 5'd18, 5'd6, op_iw), 5'd18, 64'hffff_ffff_ffff_fffd);
        add_entry(i_type(12'hfff, 3'd0, 5'd3, 5'd2, op_iw), 5'd3, 64'h0000_0000_7fff_ffff);
        add_entry(i_type(12'h004, 3'd5, 5'd3, 5'd6, op_iw), 5'd3, 64'h0000_0000_0fff_ffff);
        add_entry(i_type(12'h021, 3'd0, 5'd20, 5'd0, op_i), 5'd20, 64'h21);
        add_entry(r_type(7'h00, 3'd5, 5'd21, 5'd2, 5'd20, op_rw), 5'd21, 64'h0000_0000_4000_0000);
        gap_next = 2'd2;  // consumers issue 3 cycles after their producer.
        add_entry(i_type(12'h064, 3'd0, 5'd22, 5'd0, op_i), 5'd22, 64'h64);
        add_entry(i_type(12'h001, 3'd0, 5'd23, 5'd22, op_i), 5'd23, 64'h65);
        gap_next = 2'd3;
        add_entry(r_type(7'h00, 3'd0, 5'd24, 5'd23, 5'd22, op_r), 5'd24, 64'hc9);
        gap_next = 2'd0;
        add_entry(i_type(12'h001, 3'd0, 5'd25, 5'd0, op_i), 5'd25, 64'h1);
        add_entry(i_type(12'h002, 3'd0, 5'd26, 5'd0, op_i), 5'd26, 64'h2);
        add_entry(i_type(12'h003, 3'd0, 5'd27, 5'd0, op_i), 5'd27, 64'h3);
        gap_next = 2'd3;
        add_entry(i_type(12'h00f, 3'd4, 5'd28, 5'd7, op_i), 5'd28, 64'hc);
        add_entry(i_type(12'h005, 3'd0, 5'd0, 5'd7, op_i), 5'd0, 64'h0);
        add_entry(r_type(7'h00, 3'd0, 5'd5, 5'd6, 5'd7, 7'h7f), 5'd0, 64'h0);
        add_entry(r_type(7'h00, 3'd0, 5'd29, 5'd0, 5'd0, op_r), 5'd29, 64'h0);
        add_entry(r_type(7'h00, 3'd0, 5'd31, 5'd5, 5'd0, op_r), 5'd31, 64'h0000_0000_0000_2000);
    endtask

    int_core u_int_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .pc_i         (pc),
        .wb_valid_o   (wb_valid),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data)
    );

    int_core_checker u_checker (
        .clk      (clk),
        .rst_n    (rst_n),
        .expect_i (expect_wb),
        .wb_i     ({wb_valid, wb_rd, wb_data}),
        .final_i  (final_check),
        .errors_o (errors),
        .seen_o   (seen)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > 10 + 7 * table_q.size() + 50) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        int extra;
        void'($urandom(26));
        rst_n       = 1'b0;
        inst_valid  = 1'b0;
        inst        = '0;
        pc          = '0;
        expect_wb   = '0;
        final_check = 1'b0;
        fill_table();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        foreach (table_q[i]) begin
            @(posedge clk);
            inst_valid <= 1'b1;
            inst       <= table_q[i].inst;
            pc         <= table_q[i].pc;
            expect_wb  <= {table_q[i].rd != 5'd0, table_q[i].rd, table_q[i].data};
            if (table_q[i].gap != 2'd0) begin
                @(posedge clk);
                inst_valid <= 1'b0;
                expect_wb  <= '0;
                repeat (table_q[i].gap - 1) @(posedge clk);
                if (table_q[i].gap == 2'd3) begin
                    extra = $urandom % 3;
                    repeat (extra) @(posedge clk);
                end
            end
        end
        @(posedge clk);
        inst_valid <= 1'b0;
        expect_wb  <= '0;
        repeat (5) @(posedge clk);  // the pipeline is three stages deep.
        final_check <= 1'b1;
        @(posedge clk);
        final_check <= 1'b0;
        @(posedge clk);
        $display("%0d writebacks checked, %0d errors", seen, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/int_core_checker.sv ====
// writeback checker
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module int_core_checker
    import core_pipe_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire wb_t  expect_i,
    input  wire wb_t  wb_i,
    input  wire logic final_i,
    output int        errors_o,
    output int        seen_o
);

    wb_t expect_q[$];
    int  push_cycle_q[$];
    int  cycle;
    int  latency;
    wb_t want;

    initial begin
        errors_o = 0;
        seen_o   = 0;
        cycle    = 0;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (expect_i.valid) begin
            expect_q.push_back(expect_i);
            push_cycle_q.push_back(cycle);  // the same edge samples inst_valid_i.
        end
        if (rst_n && wb_i.valid) begin
            seen_o = seen_o + 1;
            if (expect_q.size() == 0) begin
                $display("writeback to x%0d at %0t ns arrived with no instruction pending",
                         wb_i.rd, $time);
                errors_o = errors_o + 1;
            end else begin
                want    = expect_q.pop_front();
                latency = cycle - push_cycle_q.pop_front();
                if (wb_i.rd !== want.rd) begin
                    $display("error %0t ns: wb_rd_o expected %0d actual %0d",
                             $time, want.rd, wb_i.rd);
                    errors_o = errors_o + 1;
                end
                if (wb_i.data !== want.data) begin
                    $display("error %0t ns: wb_data_o expected %h actual %h",
                             $time, want.data, wb_i.data);
                    errors_o = errors_o + 1;
                end
                if (latency != 3) begin
                    $display("error %0t ns: wb_valid_o latency expected 3 actual %0d",
                             $time, latency);
                    errors_o = errors_o + 1;
                end
            end
        end
        if (final_i && (expect_q.size() != 0)) begin
            $display("%0d expected writebacks never arrived", expect_q.size());
            errors_o = errors_o + 1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/int_core.sv ====
// rv64 integer datapath top
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module int_core
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 inst_valid_i,
    input  wire inst_u                inst_i,
    input  wire logic [`XLEN-1:0]     pc_i,
    output logic                      wb_valid_o,
    output logic [`REG_IDX_W-1:0]     wb_rd_o,
    output logic [`XLEN-1:0]          wb_data_o
);

    dec_ex_t dec;
    ex_res_t res;
    wb_t     wb;

    int_decode u_int_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .wb_i         (wb),  // writeback also feeds the register file.
        .dec_o        (dec)
    );

    int_execute u_int_execute (
        .clk   (clk),
        .rst_n (rst_n),
        .dec_i (dec),
        .res_o (res)
    );

    int_result u_int_result (
        .clk   (clk),
        .rst_n (rst_n),
        .res_i (res),
        .wb_o  (wb)
    );

    assign wb_valid_o = wb.valid;
    assign wb_rd_o    = wb.rd;
    assign wb_data_o  = wb.data;

endmodule

`default_nettype wire

// ==== hdl/int_result.sv ====
// integer result stage
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module int_result
    import core_pipe_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire ex_res_t res_i,
    output wb_t          wb_o
);

    logic [`XLEN-1:0] data_ext;

    // w results are sign-extended from bit 31.
    always_comb begin
        if (res_i.word) begin
            data_ext = {{(`XLEN-32){res_i.result[31]}}, res_i.result[31:0]};
        end else begin
            data_ext = res_i.result;
        end
    end

    always_ff @(posedge clk) begin
        wb_o.rd   <= res_i.rd;
        wb_o.data <= data_ext;
        if (!rst_n) begin
            wb_o.valid <= 1'b0;
        end else begin
            wb_o.valid <= res_i.valid && res_i.wr;  // x0 and unknown opcodes stop here.
        end
    end

endmodule

`default_nettype wire

// ==== hdl/int_execute.sv ====
// integer execute stage
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module int_execute
    import core_pipe_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire dec_ex_t dec_i,
    output ex_res_t      res_o
);

    localparam logic [`XLEN-1:0] all_ones = '1;

    logic [`XLEN-1:0]    op1;
    logic [`XLEN-1:0]    op2;
    logic [`SHAMT_W-1:0] shamt;
    logic                fill;
    logic [`XLEN-1:0]    sh_in;
    logic [`XLEN-1:0]    sh_out;
    logic [`XLEN-1:0]    alu_out;

    function automatic logic [`XLEN-1:0] bit_rev(input logic [`XLEN-1:0] v);
        logic [`XLEN-1:0] r;
        for (int i = 0; i < `XLEN; i++) begin
            r[i] = v[`XLEN-1-i];
        end
        return r;
    endfunction

    always_comb begin
        case (dec_i.op1_sel)
            op1_pc:   op1 = dec_i.pc;
            op1_zero: op1 = '0;
            default:  op1 = dec_i.rs1_val;
        endcase
        op2 = (dec_i.op2_sel == op2_imm) ? dec_i.imm : dec_i.rs2_val;
    end

    // one right shifter serves sll too, through bit reversal.
    always_comb begin
        shamt = dec_i.word ? {1'b0, op2[`SHAMT_W32-1:0]} : op2[`SHAMT_W-1:0];
        fill  = (dec_i.alu_op == alu_sra) && (dec_i.word ? op1[31] : op1[`XLEN-1]);
        if (dec_i.alu_op == alu_sll) begin
            sh_in = bit_rev(op1);
        end else if (dec_i.word) begin
            sh_in = {{(`XLEN-32){fill}}, op1[31:0]};
        end else begin
            sh_in = op1;
        end
        sh_out = sh_in;
        for (int s = 0; s < `SHAMT_W; s++) begin
            if (shamt[s]) begin
                sh_out = (sh_out >> (1 << s)) | (fill ? ~(all_ones >> (1 << s)) : '0);
            end
        end
    end

    always_comb begin
        case (dec_i.alu_op)
            alu_add:  alu_out = op1 + op2;
            alu_sub:  alu_out = op1 - op2;
            alu_sll:  alu_out = bit_rev(sh_out);
            alu_slt:  alu_out = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            alu_sltu: alu_out = {{(`XLEN-1){1'b0}}, op1 < op2};
            alu_xor:  alu_out = op1 ^ op2;
            alu_srl:  alu_out = sh_out;
            alu_sra:  alu_out = sh_out;
            alu_or:   alu_out = op1 | op2;
            default:  alu_out = op1 & op2;
        endcase
    end

    always_ff @(posedge clk) begin
        res_o.wr     <= dec_i.wr;
        res_o.word   <= dec_i.word;
        res_o.rd     <= dec_i.rd;
        res_o.result <= alu_out;
        if (!rst_n) begin
            res_o.valid <= 1'b0;
        end else begin
            res_o.valid <= dec_i.valid;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/int_decode.sv ====
// integer decode stage
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module int_decode
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             inst_valid_i,
    input  wire inst_u            inst_i,
    input  wire logic [`XLEN-1:0] pc_i,
    input  wire wb_t              wb_i,
    output dec_ex_t               dec_o
);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic             known;
    logic             is_imm;
    logic             is_upper;
    logic             is_word;
    logic             is_shift;
    logic             alt;
    logic [11:0]      imm_i;
    logic [`XLEN-1:0] imm;
    op1_sel_e         op1_sel;
    alu_op_e          alu_op;
    dec_ex_t          dec_d;

    // a write on this edge is seen by the read in the same cycle.
    function automatic logic [`XLEN-1:0] read_reg(input logic [`REG_IDX_W-1:0] idx);
        if (wb_i.valid && (wb_i.rd == idx) && (idx != '0)) begin
            return wb_i.data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        known    = 1'b1;
        is_imm   = 1'b0;
        is_upper = 1'b0;
        is_word  = 1'b0;
        op1_sel  = op1_reg;
        case (inst_i.r.opcode)
            opc_lui: begin
                is_upper = 1'b1;
                op1_sel  = op1_zero;
            end
            opc_auipc: begin
                is_upper = 1'b1;
                op1_sel  = op1_pc;
            end
            opc_op_imm: is_imm = 1'b1;
            opc_op: known = 1'b1;
            opc_op_imm_32: begin
                is_imm  = 1'b1;
                is_word = 1'b1;
            end
            opc_op_32: is_word = 1'b1;
            default: known = 1'b0;
        endcase
    end

    assign alt      = inst_i.r.funct7[f7_alt_bit];
    assign imm_i    = inst_i.iu.imm20[19:8];
    assign is_shift = (inst_i.r.funct3 == f3_sll) || (inst_i.r.funct3 == f3_sr);

    always_comb begin
        case (inst_i.r.funct3)
            f3_add:  alu_op = (alt && !is_imm) ? alu_sub : alu_add;  // addi has no sub.
            f3_sll:  alu_op = alu_sll;
            f3_slt:  alu_op = alu_slt;
            f3_sltu: alu_op = alu_sltu;
            f3_xor:  alu_op = alu_xor;
            f3_sr:   alu_op = alt ? alu_sra : alu_srl;
            f3_or:   alu_op = alu_or;
            default: alu_op = alu_and;
        endcase
        if (is_upper) begin
            alu_op = alu_add;
        end
    end

    always_comb begin
        if (is_upper) begin
            imm = {{(`XLEN-`ILEN){imm_i[11]}}, inst_i.iu.imm20, 12'b0};
        end else if (is_shift) begin
            imm = {{(`XLEN-`SHAMT_W){1'b0}}, imm_i[`SHAMT_W-1:0]};  // drops the sra flag.
        end else begin
            imm = {{(`XLEN-12){imm_i[11]}}, imm_i};
        end
    end

    always_comb begin
        dec_d.valid   = inst_valid_i;
        dec_d.alu_op  = alu_op;
        dec_d.op1_sel = op1_sel;
        dec_d.op2_sel = (is_imm || is_upper) ? op2_imm : op2_reg;
        dec_d.word    = is_word;
        dec_d.rd      = inst_i.r.rd;
        dec_d.wr      = known && (inst_i.r.rd != '0);
        dec_d.rs1_val = read_reg(inst_i.r.rs1);
        dec_d.rs2_val = read_reg(inst_i.r.rs2);
        dec_d.imm     = imm;
        dec_d.pc      = pc_i;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid && (wb_i.rd != '0)) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    always_ff @(posedge clk) begin
        dec_o <= dec_d;
        if (!rst_n) begin
            dec_o.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/core_pipe_pkg.sv ====
// pipeline stage types
`default_nettype none

`include "core_consts.svh"

package core_pipe_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    typedef enum logic [1:0] {
        op1_reg,
        op1_pc,
        op1_zero  // used by lui.
    } op1_sel_e;

    typedef enum logic {
        op2_reg,
        op2_imm
    } op2_sel_e;

    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        op1_sel_e              op1_sel;
        op2_sel_e              op2_sel;
        logic                  word;  // 32-bit w operation.
        logic [`REG_IDX_W-1:0] rd;
        logic                  wr;
        logic [`XLEN-1:0]      rs1_val;
        logic [`XLEN-1:0]      rs2_val;
        logic [`XLEN-1:0]      imm;
        logic [`XLEN-1:0]      pc;
    } dec_ex_t;

    typedef struct packed {
        logic                  valid;
        logic                  wr;
        logic                  word;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      result;
    } ex_res_t;

    typedef struct packed {
        logic                  valid;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      data;
    } wb_t;

endpackage

`default_nettype wire

// ==== hdl/rv_isa_pkg.sv ====
// rv64 instruction set definitions
`default_nettype none

`include "core_consts.svh"

package rv_isa_pkg;

    typedef enum logic [6:0] {
        opc_lui       = 7'b0110111,
        opc_auipc     = 7'b0010111,
        opc_op_imm    = 7'b0010011,
        opc_op        = 7'b0110011,
        opc_op_imm_32 = 7'b0011011,
        opc_op_32     = 7'b0111011
    } opcode_e;

    localparam logic [2:0] f3_add  = 3'b000;  // sub shares this code.
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;  // srl and sra.
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // funct7 bit that selects sub and sra.
    localparam int f7_alt_bit = 5;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`REG_IDX_W-1:0] rd;
        opcode_e               opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [19:0]           imm20;  // the i-type immediate is the top 12 bits.
        logic [`REG_IDX_W-1:0] rd;
        opcode_e               opcode;
    } iu_fmt_t;

    typedef union packed {
        r_fmt_t  r;
        iu_fmt_t iu;
    } inst_u;

endpackage

`default_nettype wire

// ==== hdl/core_consts.svh ====
// integer core constants
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath width of the rv64 core.
`define XLEN 64

// integer register file.
`define NUM_REGS 32
`define REG_IDX_W 5

// shift amounts for 64-bit and word operations.
`define SHAMT_W 6
`define SHAMT_W32 5

// instruction word width.
`define ILEN 32

`endif
